//--- build.f
logic/calc_cfg_pkg.sv
logic/calc_pkt_pkg.sv
logic/calc_issue.sv
logic/calc_exe_pipes.sv
logic/calc_comp_pipe.sv
logic/calc_top.sv
test/calc_tb_asserts.sv
test/calc_tb.sv

//--- logic/calc_cfg_pkg.sv
// ================================================
// Sizing constants for the execution calculator
// Widths of operands and register addresses, and
// the default completion depth and multiply
// latency picked up by the top level parameters
// ================================================

package calc_cfg_pkg;

  // Operand and result width
  parameter int data_width = 32;

  // Register 0 always reads as zero
  parameter int reg_addr_width = 5;

  // Completion stages between dispatch and writeback
  parameter int comp_depth_default = 4;

  // Multiply result merges into this completion stage
  parameter int mul_latency_default = 3;

  typedef logic [data_width-1:0]     data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

endpackage

//--- logic/calc_comp_pipe.sv
// ================================================
// Completion pipe of the execution calculator
// Shifts every instruction one stage per cycle
// and merges pipe results at their static stage.
// The last stage is the writeback packet, the
// next-stage data array feeds operand bypass
// ================================================

`timescale 1ns/1ns

module calc_comp_pipe
  #(parameter int comp_depth_p  = calc_cfg_pkg::comp_depth_default
  , parameter int mul_latency_p = calc_cfg_pkg::mul_latency_default
  )
  (input  logic                                       clk_i
  , input  logic                                      rst_n_i
  , input  calc_pkt_pkg::wb_s                         stage0_i
  , input  calc_pkt_pkg::result_s                     int_res_i
  , input  calc_pkt_pkg::result_s                     mul_res_i
  , output calc_pkt_pkg::wb_s   [comp_depth_p-1:0]    stage_hdr_o
  , output calc_cfg_pkg::data_t [comp_depth_p-1:0]    fwd_data_o
  , output calc_pkt_pkg::wb_s                         wb_o
  );

  calc_pkt_pkg::wb_s [comp_depth_p:0]   stage_n;
  calc_pkt_pkg::wb_s [comp_depth_p-1:0] stage_r;

  // Single issue with static latencies, so at most one pipe
  // lands in a given stage and an OR merge is enough
  always_comb
  begin
    stage_n[0] = stage0_i;
    for (int i = 1; i <= comp_depth_p; i++)
    begin
      stage_n[i] = stage_r[i-1];
    end

    stage_n[1].data             |= int_res_i.v ? int_res_i.data : '0;
    stage_n[mul_latency_p].data |= mul_res_i.v ? mul_res_i.data : '0;
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < comp_depth_p; i++)
    begin
      if (!rst_n_i)
      begin
        stage_r[i].w_v <= 1'b0;
      end
      else
      begin
        stage_r[i].w_v <= stage_n[i].w_v;
      end
      stage_r[i].rd   <= stage_n[i].rd;
      stage_r[i].data <= stage_n[i].data;
    end
  end

  // A match on stage i sees what stage i+1 is about to hold
  always_comb
  begin
    for (int i = 0; i < comp_depth_p; i++)
    begin
      fwd_data_o[i] = stage_n[i+1].data;
    end
  end

  assign stage_hdr_o = stage_r;
  assign wb_o        = stage_r[comp_depth_p-1];

endmodule

//--- logic/calc_exe_pipes.sv
// ================================================
// Execution pipes of the calculator
// Integer pipe works on the reservation in the
// same cycle. The multiplier forms the low half
// of the product from the reservation and shifts
// it down a chain of registers, so several
// multiplies can be in flight at once
// ================================================

`timescale 1ns/1ns

module calc_exe_pipes
  #(parameter int mul_latency_p = calc_cfg_pkg::mul_latency_default)
  (input  logic                   clk_i
  , input  logic                  rst_n_i
  , input  calc_pkt_pkg::resv_s   resv_i
  , output calc_pkt_pkg::result_s int_res_o
  , output calc_pkt_pkg::result_s mul_res_o
  );

  calc_pkt_pkg::result_s                   mul_first;
  calc_pkt_pkg::result_s [mul_latency_p:2] mul_r;

  // Integer pipe
  always_comb
  begin
    int_res_o.v = resv_i.v & ((resv_i.op == calc_pkt_pkg::op_add)
                             | (resv_i.op == calc_pkt_pkg::op_sub)
                             | (resv_i.op == calc_pkt_pkg::op_xor));
    case (resv_i.op)
      calc_pkt_pkg::op_add: int_res_o.data = resv_i.rs1 + resv_i.rs2;
      calc_pkt_pkg::op_sub: int_res_o.data = resv_i.rs1 - resv_i.rs2;
      calc_pkt_pkg::op_xor: int_res_o.data = resv_i.rs1 ^ resv_i.rs2;
      default:              int_res_o.data = '0;
    endcase
  end

  // First multiply stage, only the low half is kept
  always_comb
  begin
    mul_first.v    = resv_i.v & (resv_i.op == calc_pkt_pkg::op_mul);
    mul_first.data = resv_i.rs1 * resv_i.rs2;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int k = 2; k <= mul_latency_p; k++)
      begin
        mul_r[k].v <= 1'b0;
      end
    end
    else
    begin
      mul_r[2].v <= mul_first.v;
      for (int k = 3; k <= mul_latency_p; k++)
      begin
        mul_r[k].v <= mul_r[k-1].v;
      end
    end

    mul_r[2].data <= mul_first.data;
    for (int k = 3; k <= mul_latency_p; k++)
    begin
      mul_r[k].data <= mul_r[k-1].data;
    end
  end

  assign mul_res_o = mul_r[mul_latency_p];

endmodule

//--- logic/calc_issue.sv
// ================================================
// Issue stage of the execution calculator
// Replaces stale register operands with results
// still in flight in the completion pipe, then
// registers the reservation for the exe pipes.
// Also forms the completion stage 0 header
// ================================================

`timescale 1ns/1ns

module calc_issue
  #(parameter int comp_depth_p = calc_cfg_pkg::comp_depth_default)
  (input  logic                                       clk_i
  , input  logic                                      rst_n_i
  , input  calc_pkt_pkg::dispatch_s                   dispatch_i
  , input  calc_pkt_pkg::wb_s   [comp_depth_p-1:0]    stage_hdr_i
  , input  calc_cfg_pkg::data_t [comp_depth_p-1:0]    fwd_data_i
  , output calc_pkt_pkg::wb_s                         stage0_o
  , output calc_pkt_pkg::resv_s                       resv_o
  );

  logic                                 is_li;
  logic                    [1:0]        src_bypass_en;
  calc_cfg_pkg::reg_addr_t [1:0]        src_addr;
  calc_cfg_pkg::data_t     [1:0]        src_data;
  logic [1:0][comp_depth_p-1:0]         match_rs;
  calc_cfg_pkg::data_t     [1:0]        bypass_rs;
  calc_pkt_pkg::resv_s                  resv_n;

  assign is_li = (dispatch_i.op == calc_pkt_pkg::op_li);

  // Index 0 is rs1, index 1 is rs2
  assign src_addr = {dispatch_i.rs2_addr, dispatch_i.rs1_addr};
  assign src_data = {dispatch_i.rs2_data, dispatch_i.rs1_data};

  // The li payload in rs2 is not a register read
  assign src_bypass_en = {dispatch_i.v & ~is_li, dispatch_i.v};

  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      for (int i = 0; i < comp_depth_p; i++)
      begin
        match_rs[s][i] = src_bypass_en[s]
                         & stage_hdr_i[i].w_v
                         & (src_addr[s] == stage_hdr_i[i].rd);
      end

      // Lowest stage is the youngest producer, so it is checked last
      bypass_rs[s] = src_data[s];
      for (int i = comp_depth_p-1; i >= 0; i--)
      begin
        if (match_rs[s][i])
        begin
          bypass_rs[s] = fwd_data_i[i];
        end
      end
    end
  end

  always_comb
  begin
    resv_n.v   = dispatch_i.v;
    resv_n.op  = dispatch_i.op;
    resv_n.rd  = dispatch_i.rd;
    resv_n.rs1 = bypass_rs[0];
    resv_n.rs2 = bypass_rs[1];
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resv_o.v <= 1'b0;
    end
    else
    begin
      resv_o.v <= resv_n.v;
    end
    resv_o.op  <= resv_n.op;
    resv_o.rd  <= resv_n.rd;
    resv_o.rs1 <= resv_n.rs1;
    resv_o.rs2 <= resv_n.rs2;
  end

  // Stage 0 header, li injects its payload here
  always_comb
  begin
    stage0_o.w_v  = dispatch_i.v & (dispatch_i.rd != '0);
    stage0_o.rd   = dispatch_i.rd;
    stage0_o.data = (dispatch_i.v & is_li) ? dispatch_i.rs2_data : '0;
  end

endmodule

//--- logic/calc_pkt_pkg.sv
// ================================================
// Packet formats of the execution calculator
// Operation codes and the structs passed between
// issue, execution pipes and completion pipe
// ================================================

package calc_pkt_pkg;

  typedef enum logic [2:0]
  {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_xor = 3'd2,
    op_mul = 3'd3,
    op_li  = 3'd4
  } op_e;

  // Instruction as handed over by dispatch, operands may be stale
  typedef struct packed
  {
    logic                    v;
    op_e                     op;
    calc_cfg_pkg::reg_addr_t rd;
    calc_cfg_pkg::reg_addr_t rs1_addr;
    calc_cfg_pkg::reg_addr_t rs2_addr;
    calc_cfg_pkg::data_t     rs1_data;
    // Load-immediate payload rides here
    calc_cfg_pkg::data_t     rs2_data;
  } dispatch_s;

  // Reservation with bypassed operands
  typedef struct packed
  {
    logic                    v;
    op_e                     op;
    calc_cfg_pkg::reg_addr_t rd;
    calc_cfg_pkg::data_t     rs1;
    calc_cfg_pkg::data_t     rs2;
  } resv_s;

  typedef struct packed
  {
    logic                    w_v;
    calc_cfg_pkg::reg_addr_t rd;
    calc_cfg_pkg::data_t     data;
  } wb_s;

  typedef struct packed
  {
    logic                v;
    calc_cfg_pkg::data_t data;
  } result_s;

endpackage

//--- logic/calc_top.sv
// ================================================
// Top level of the execution calculator
// Takes one dispatched instruction per cycle and
// retires it in order on wb_o after a fixed
// completion depth, with operand bypass from
// results still in flight
// ================================================

`timescale 1ns/1ns

module calc_top
  #(parameter int comp_depth_p  = calc_cfg_pkg::comp_depth_default
  , parameter int mul_latency_p = calc_cfg_pkg::mul_latency_default
  )
  (input  logic                     clk_i
  , input  logic                    rst_n_i
  , input  calc_pkt_pkg::dispatch_s dispatch_i
  , output calc_pkt_pkg::wb_s       wb_o
  );

  calc_pkt_pkg::wb_s                        stage0;
  calc_pkt_pkg::resv_s                      resv;
  calc_pkt_pkg::result_s                    int_res;
  calc_pkt_pkg::result_s                    mul_res;
  calc_pkt_pkg::wb_s   [comp_depth_p-1:0]   stage_hdr;
  calc_cfg_pkg::data_t [comp_depth_p-1:0]   fwd_data;

  calc_issue
    #(.comp_depth_p(comp_depth_p))
    i_issue
    (.clk_i        (clk_i)
    , .rst_n_i     (rst_n_i)
    , .dispatch_i  (dispatch_i)
    , .stage_hdr_i (stage_hdr)
    , .fwd_data_i  (fwd_data)
    , .stage0_o    (stage0)
    , .resv_o      (resv)
    );

  calc_exe_pipes
    #(.mul_latency_p(mul_latency_p))
    i_exe_pipes
    (.clk_i      (clk_i)
    , .rst_n_i   (rst_n_i)
    , .resv_i    (resv)
    , .int_res_o (int_res)
    , .mul_res_o (mul_res)
    );

  calc_comp_pipe
    #(.comp_depth_p (comp_depth_p)
    , .mul_latency_p(mul_latency_p)
    )
    i_comp_pipe
    (.clk_i        (clk_i)
    , .rst_n_i     (rst_n_i)
    , .stage0_i    (stage0)
    , .int_res_i   (int_res)
    , .mul_res_i   (mul_res)
    , .stage_hdr_o (stage_hdr)
    , .fwd_data_o  (fwd_data)
    , .wb_o        (wb_o)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build the calculator testbench with Verilator and run it.
# The run fails when the log holds the fail message or lacks the pass message.

rm -f sim.log

verilator --binary --timing --assert --top-module calc_tb -f build.f -o calc_sim \
  || { echo "Verilator build failed"; exit 1; }

{ ./obj_dir/calc_sim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && ! grep -qF '*** TEST FAILED ***' sim.log \
  && grep -qF '*** TEST PASSED ***' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- test/calc_tb.sv
// ==================================================
// Testbench for the execution calculator top level
// Runs directed and random programs, keeps a register
// file fed only from writeback, and checks every
// retired packet against a program order model
// ==================================================

`timescale 1ns/1ns

module calc_tb;

  localparam int comp_depth  = calc_cfg_pkg::comp_depth_default;
  localparam int mul_latency = calc_cfg_pkg::mul_latency_default;
  localparam int num_regs    = 2 ** calc_cfg_pkg::reg_addr_width;
  localparam int clk_period  = 4;
  localparam int rst_cycles  = 8;
  localparam int n_indep     = 40;
  localparam int n_chain     = 80;
  localparam int n_mul       = 80;
  localparam int n_zero      = 40;
  localparam int n_rand      = 150;
  // Up to two hazard bubbles and one random idle per instruction
  localparam int test_cycles = rst_cycles + 20 + 8 * comp_depth
                             + 4 * (num_regs + n_indep + n_chain + n_mul + n_zero + n_rand + 9);
  localparam int timeout_ns  = test_cycles * clk_period + 200;

  typedef struct packed
  {
    logic [31:0]       due;
    logic [2:0]        tid;
    calc_pkt_pkg::wb_s wb;
  } exp_s;

  typedef struct packed
  {
    logic                    v;
    calc_cfg_pkg::reg_addr_t rd;
  } pend_s;

  logic                    clk_i;
  logic                    rst_n_i;
  calc_pkt_pkg::dispatch_s dispatch_i;
  calc_pkt_pkg::wb_s       wb_o;

  logic                    checking;
  logic [2:0]              cur_tid;
  int unsigned             cyc;
  calc_cfg_pkg::data_t     rf_model [num_regs];
  calc_cfg_pkg::data_t     arch_rf  [num_regs];
  calc_cfg_pkg::reg_addr_t last_rd  [4];
  pend_s                   mul_hist [mul_latency-1];
  exp_s                    exp_q    [$];
  string                   test_names [7];

  calc_top
    #(.comp_depth_p (comp_depth)
    , .mul_latency_p(mul_latency)
    )
    i_calc_top
    (.clk_i       (clk_i)
    , .rst_n_i    (rst_n_i)
    , .dispatch_i (dispatch_i)
    , .wb_o       (wb_o)
    );

  bind calc_top calc_tb_asserts #(.comp_depth_p(comp_depth_p)) i_calc_tb_asserts
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .dispatch_i(dispatch_i), .wb_i(wb_o));

  always #(clk_period/2) clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
  end

  task automatic fail_stop();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_wb(input logic [2:0] tid, input calc_pkt_pkg::wb_s exp_wb,
                          input calc_pkt_pkg::wb_s act_wb);
    if (act_wb !== exp_wb)
    begin
      $display("MISMATCH %s: expected w_v=%0b rd=%0d data=%h, actual w_v=%0b rd=%0d data=%h",
               test_names[tid], exp_wb.w_v, exp_wb.rd, exp_wb.data,
               act_wb.w_v, act_wb.rd, act_wb.data);
      fail_stop();
    end
  endtask

  task automatic check_idle(input logic [2:0] tid, input calc_pkt_pkg::wb_s act_wb);
    if (act_wb.w_v !== 1'b0)
    begin
      $display("MISMATCH %s: expected w_v=0, actual w_v=%0b rd=%0d data=%h",
               test_names[tid], act_wb.w_v, act_wb.rd, act_wb.data);
      fail_stop();
    end
  endtask

  function automatic calc_cfg_pkg::data_t ref_result(input calc_pkt_pkg::op_e op,
                                                     input calc_cfg_pkg::data_t a,
                                                     input calc_cfg_pkg::data_t b);
    logic [2*calc_cfg_pkg::data_width-1:0] prod;
    prod = {{calc_cfg_pkg::data_width{1'b0}}, a} * {{calc_cfg_pkg::data_width{1'b0}}, b};
    case (op)
      calc_pkt_pkg::op_add: return a + b;
      calc_pkt_pkg::op_sub: return a - b;
      calc_pkt_pkg::op_xor: return a ^ b;
      calc_pkt_pkg::op_mul: return prod[calc_cfg_pkg::data_width-1:0];
      default:              return b;
    endcase
  endfunction

  function automatic calc_cfg_pkg::reg_addr_t rand_reg(input int lo, input int hi);
    return calc_cfg_pkg::reg_addr_t'($urandom_range(hi, lo));
  endfunction

  function automatic calc_pkt_pkg::op_e rand_op(input logic with_mul);
    int unsigned k;
    k = $urandom_range(with_mul ? 4 : 3, 0);
    case (k)
      0:       return calc_pkt_pkg::op_add;
      1:       return calc_pkt_pkg::op_sub;
      2:       return calc_pkt_pkg::op_xor;
      3:       return calc_pkt_pkg::op_li;
      default: return calc_pkt_pkg::op_mul;
    endcase
  endfunction

  // Scheduling rule forbids reading a multiply rd still inside the multiplier
  function automatic logic reads_pending_mul(input calc_pkt_pkg::dispatch_s d);
    logic hit;
    hit = 1'b0;
    if (d.op != calc_pkt_pkg::op_li)
    begin
      for (int h = 0; h < mul_latency-1; h++)
      begin
        if (mul_hist[h].v && (mul_hist[h].rd == d.rs1_addr || mul_hist[h].rd == d.rs2_addr))
        begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  function automatic void note_slot(input calc_pkt_pkg::dispatch_s d);
    for (int h = mul_latency-2; h > 0; h--)
    begin
      mul_hist[h] = mul_hist[h-1];
    end
    mul_hist[0].v  = d.v && (d.op == calc_pkt_pkg::op_mul) && (d.rd != '0);
    mul_hist[0].rd = d.rd;
  endfunction

  task automatic drive_idle();
    @(posedge clk_i);
    dispatch_i <= '0;
    note_slot('0);
  endtask

  task automatic issue(input calc_pkt_pkg::op_e op, input calc_cfg_pkg::reg_addr_t rd,
                       input calc_cfg_pkg::reg_addr_t rs1, input calc_cfg_pkg::reg_addr_t rs2,
                       input calc_cfg_pkg::data_t imm);
    calc_pkt_pkg::dispatch_s d;
    calc_cfg_pkg::data_t     b;
    exp_s                    e;
    d          = '0;
    d.v        = 1'b1;
    d.op       = op;
    d.rd       = rd;
    d.rs1_addr = rs1;
    d.rs2_addr = rs2;
    while (reads_pending_mul(d))
    begin
      drive_idle();
    end
    @(posedge clk_i);
    // Register file values may be stale and the DUT bypass fixes them
    d.rs1_data = rf_model[rs1];
    d.rs2_data = (op == calc_pkt_pkg::op_li) ? imm : rf_model[rs2];
    dispatch_i <= d;
    note_slot(d);
    b = (op == calc_pkt_pkg::op_li) ? imm : arch_rf[rs2];
    if (rd != '0)
    begin
      // cyc has not yet counted this edge
      e.due     = cyc + 1 + comp_depth;
      e.tid     = cur_tid;
      e.wb.w_v  = 1'b1;
      e.wb.rd   = rd;
      e.wb.data = ref_result(op, arch_rf[rs1], b);
      exp_q.push_back(e);
      arch_rf[rd] = e.wb.data;
    end
    for (int i = 3; i > 0; i--)
    begin
      last_rd[i] = last_rd[i-1];
    end
    last_rd[0] = rd;
  endtask

  task automatic begin_test(input logic [2:0] tid);
    repeat (comp_depth) drive_idle();
    cur_tid = tid;
  endtask

  always @(negedge clk_i)
  begin
    if (checking)
    begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc)
      begin
        check_wb(exp_q[0].tid, exp_q[0].wb, wb_o);
        void'(exp_q.pop_front());
      end
      else
      begin
        check_idle(cur_tid, wb_o);
      end
      if (wb_o.w_v)
      begin
        rf_model[wb_o.rd] = wb_o.data;
      end
    end
  end

  initial
  begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns, writeback never finished", timeout_ns);
    fail_stop();
  end

  initial
  begin
    calc_pkt_pkg::dispatch_s probe;
    void'($urandom(32'hd8caba3f));
    test_names = '{"reset_idle", "li_init", "indep_int", "dep_chain", "mul_fwd",
                   "reg_zero", "random_mix"};
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    dispatch_i = '0;
    checking   = 1'b0;
    cur_tid    = 3'd0;
    cyc        = 0;
    for (int r = 0; r < num_regs; r++)
    begin
      rf_model[r] = '0;
      arch_rf[r]  = '0;
    end
    for (int i = 0; i < 4; i++)
    begin
      last_rd[i] = '0;
    end
    for (int h = 0; h < mul_latency-1; h++)
    begin
      mul_hist[h] = '0;
    end
    probe          = '0;
    probe.v        = 1'b1;
    probe.op       = calc_pkt_pkg::op_li;
    probe.rs2_data = 32'hffff_ffff;

    // Valid dispatches early in reset must never retire
    for (int n = 1; n < rst_cycles / 2; n++)
    begin
      @(posedge clk_i);
      probe.rd   = calc_cfg_pkg::reg_addr_t'(n);
      dispatch_i <= probe;
    end
    @(posedge clk_i);
    dispatch_i <= '0;
    repeat (rst_cycles - rst_cycles / 2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    checking = 1'b1;
    repeat (20) drive_idle();

    begin_test(3'd1);
    for (int r = 1; r < num_regs; r++)
    begin
      issue(calc_pkt_pkg::op_li, calc_cfg_pkg::reg_addr_t'(r), '0, '0, $urandom());
    end

    // Sources and destinations kept apart
    begin_test(3'd2);
    repeat (n_indep) issue(rand_op(1'b0), rand_reg(16, 31), rand_reg(1, 15),
                           rand_reg(1, 15), $urandom());

    begin_test(3'd3);
    for (int n = 0; n < n_chain; n++)
    begin
      if ($urandom_range(3, 0) == 0)
      begin
        drive_idle();
      end
      issue(rand_op(1'b0), rand_reg(1, 31), last_rd[0], last_rd[$urandom_range(3, 0)],
            $urandom());
    end

    begin_test(3'd4);
    issue(calc_pkt_pkg::op_li,  5'd1, '0,   '0,   $urandom());
    issue(calc_pkt_pkg::op_li,  5'd2, '0,   '0,   $urandom());
    issue(calc_pkt_pkg::op_add, 5'd3, 5'd1, 5'd2, '0);
    issue(calc_pkt_pkg::op_mul, 5'd4, 5'd3, 5'd2, '0);
    issue(calc_pkt_pkg::op_xor, 5'd5, 5'd1, 5'd2, '0);
    issue(calc_pkt_pkg::op_li,  5'd6, '0,   '0,   $urandom());
    issue(calc_pkt_pkg::op_add, 5'd7, 5'd4, 5'd3, '0);
    issue(calc_pkt_pkg::op_mul, 5'd8, 5'd4, 5'd4, '0);
    issue(calc_pkt_pkg::op_sub, 5'd9, 5'd8, 5'd7, '0);
    repeat (n_mul) issue(rand_op(1'b1), rand_reg(1, 31), last_rd[$urandom_range(3, 0)],
                         last_rd[$urandom_range(3, 0)], $urandom());

    begin_test(3'd5);
    repeat (n_zero) issue(rand_op(1'b1), rand_reg(0, 2), rand_reg(0, 2), rand_reg(0, 2),
                          $urandom());

    begin_test(3'd6);
    for (int n = 0; n < n_rand; n++)
    begin
      if ($urandom_range(3, 0) == 0)
      begin
        drive_idle();
      end
      issue(rand_op(1'b1), rand_reg(0, 31), rand_reg(0, 31), rand_reg(0, 31), $urandom());
    end

    repeat (comp_depth + 2) drive_idle();
    if (exp_q.size() != 0)
    begin
      $display("%0d expected writebacks never appeared on wb_o", exp_q.size());
      fail_stop();
    end
    else
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- test/calc_tb_asserts.sv
// ==================================================
// Concurrent checks on the calculator top level
// Bound onto calc_top from the testbench, watches
// dispatch and writeback at the top level ports
// ==================================================

`timescale 1ns/1ns

module calc_tb_asserts
  #(parameter int comp_depth_p = calc_cfg_pkg::comp_depth_default)
  (input  logic                    clk_i
  , input  logic                   rst_n_i
  , input  calc_pkt_pkg::dispatch_s dispatch_i
  , input  calc_pkt_pkg::wb_s       wb_i
  );

  // Register 0 is never a writeback target
  a_no_rd_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_i.w_v |-> (wb_i.rd != '0))
    else $error("writeback valid with rd 0");

  // Stage valids clear on a reset edge
  a_idle_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !wb_i.w_v)
    else $error("writeback valid while in reset");

  // Fixed completion depth, same rd
  a_retire_depth: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(dispatch_i.v && (dispatch_i.rd != '0), comp_depth_p)
    |-> (wb_i.w_v && (wb_i.rd == $past(dispatch_i.rd, comp_depth_p))))
    else $error("dispatch did not retire at the completion depth");

endmodule
